// File: hw/grid_pkg.sv
`default_nettype none

package grid_pkg;

	// stored state of one grid cell
	typedef enum logic [1:0] {
		CELL_EMPTY = 2'd0,
		CELL_SHIP  = 2'd1,
		CELL_HIT   = 2'd2,
		CELL_MISS  = 2'd3
	} cell_state_e;

	// what a click does, picked by the mode switch
	typedef enum logic {
		MODE_PLACE = 1'b0, // toggle empty and ship
		MODE_FIRE  = 1'b1  // shoot at the cell
	} click_mode_e;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// cell coordinates, up to 16 per side
	typedef struct packed {
		logic [3:0] x;
		logic [3:0] y;
	} cell_idx_t;

	// raster position from the sync generator
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active; // inside the visible area
	} pixel_pos_t;

	typedef struct packed {
		rgb_t rgb;
		logic hsync; // active low
		logic vsync; // active low
	} vga_out_t;

	typedef struct packed {
		logic east;
		logic west;
		logic north;
		logic south;
	} buttons_t;

	localparam rgb_t COLOR_EMPTY       = '{r: 4'h0, g: 4'h0, b: 4'hf}; // sea blue
	localparam rgb_t COLOR_SHIP        = '{r: 4'h8, g: 4'h8, b: 4'h8}; // grey hull
	localparam rgb_t COLOR_HIT         = '{r: 4'hf, g: 4'h0, b: 4'h0};
	localparam rgb_t COLOR_MISS        = '{r: 4'hf, g: 4'hf, b: 4'hf};
	localparam rgb_t COLOR_BORDER      = '{r: 4'h3, g: 4'h3, b: 4'h3};
	localparam rgb_t COLOR_CURSOR_TINT = '{r: 4'hf, g: 4'hf, b: 4'h0}; // yellow
	localparam rgb_t COLOR_BLACK       = '{r: 4'h0, g: 4'h0, b: 4'h0};

endpackage

`default_nettype wire

// File: hw/tick_gen.sv
`default_nettype none

// one-cycle enable every DIV clocks, replaces a divided clock
module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk_in,
	input  logic rst_n,
	output logic tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt; // position inside the divide period

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else if (cnt == CW'(DIV - 1)) begin
			cnt  <= '0;
			tick <= 1'b1; // pulse on wrap
		end else begin
			cnt  <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/vga_sync.sv
`default_nettype none

module vga_sync import grid_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic       clk_in,
	input  logic       rst_n,
	input  logic       pix_tick,
	output pixel_pos_t pos,
	output logic       hsync,
	output logic       vsync
);

	localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_LO = H_ACTIVE + H_FRONT; // first pixel of the hsync pulse
	localparam int V_SYNC_LO = V_ACTIVE + V_FRONT; // first line of the vsync pulse

	logic [9:0] h_cnt;  // pixel in line
	logic [9:0] v_cnt;  // line in frame
	logic [9:0] h_next;
	logic [9:0] v_next;
	logic       active;

	// next raster position, vertical steps at end of line
	always_comb begin
		h_next = h_cnt + 10'd1;
		v_next = v_cnt;
		if (h_cnt == 10'(H_TOTAL - 1)) begin
			h_next = '0;
			if (v_cnt == 10'(V_TOTAL - 1)) begin
				v_next = '0; // frame wrap
			end else begin
				v_next = v_cnt + 10'd1;
			end
		end
	end

	// syncs and active are decoded from the next position
	// so they stay aligned with the counters
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			h_cnt  <= '0;
			v_cnt  <= '0;
			active <= 1'b1; // (0,0) is visible
			hsync  <= 1'b1;
			vsync  <= 1'b1;
		end else if (pix_tick) begin
			h_cnt  <= h_next;
			v_cnt  <= v_next;
			active <= (h_next < 10'(H_ACTIVE)) && (v_next < 10'(V_ACTIVE));
			hsync  <= !((h_next >= 10'(H_SYNC_LO)) && (h_next < 10'(H_SYNC_LO + H_SYNC)));
			vsync  <= !((v_next >= 10'(V_SYNC_LO)) && (v_next < 10'(V_SYNC_LO + V_SYNC)));
		end
	end

	assign pos = '{x: h_cnt, y: v_cnt, active: active};

	// the sync pulse must sit wholly in horizontal blanking
	a_no_sync_in_active: assert property (
		@(posedge clk_in) disable iff (!rst_n) pos.active |-> hsync
	);

endmodule

`default_nettype wire

// File: hw/pointer_mover.sv
`default_nettype none

// button driven pointer, stands in for a mouse
module pointer_mover import grid_pkg::*; #(
	parameter int GRID_N     = 10,
	parameter int CELL_SHIFT = 5
) (
	input  logic       clk_in,
	input  logic       rst_n,
	input  logic       move_tick,
	input  buttons_t   buttons,
	output logic [9:0] ptr_x,
	output logic [9:0] ptr_y
);

	localparam int PTR_MAX = (GRID_N << CELL_SHIFT) - 1; // last pixel of the grid

	buttons_t btn_meta; // first sync stage
	buttons_t btn_sync;

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= buttons;
			btn_sync <= btn_meta;
		end
	end

	// one pixel per human tick, opposing buttons cancel
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			ptr_x <= '0;
			ptr_y <= '0;
		end else if (move_tick) begin
			if (btn_sync.east && !btn_sync.west && ptr_x != 10'(PTR_MAX)) begin
				ptr_x <= ptr_x + 10'd1;
			end else if (btn_sync.west && !btn_sync.east && ptr_x != '0) begin
				ptr_x <= ptr_x - 10'd1;
			end
			// y grows downwards, like the raster
			if (btn_sync.south && !btn_sync.north && ptr_y != 10'(PTR_MAX)) begin
				ptr_y <= ptr_y + 10'd1;
			end else if (btn_sync.north && !btn_sync.south && ptr_y != '0) begin
				ptr_y <= ptr_y - 10'd1;
			end
		end
	end

	a_ptr_in_grid: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		(ptr_x <= 10'(PTR_MAX)) && (ptr_y <= 10'(PTR_MAX))
	);

endmodule

`default_nettype wire

// File: hw/grid_engine.sv
`default_nettype none

module grid_engine import grid_pkg::*; #(
	parameter int GRID_N     = 10,
	parameter int CELL_SHIFT = 5
) (
	input  logic        clk_in,
	input  logic        rst_n,
	input  logic [9:0]  ptr_x,
	input  logic [9:0]  ptr_y,
	input  logic        click,
	input  click_mode_e mode,
	input  cell_idx_t   rd_cell,
	output cell_idx_t   ptr_cell,
	output cell_state_e rd_state
);

	cell_state_e [GRID_N-1:0][GRID_N-1:0] cells; // indexed [y][x]

	logic        click_meta;
	logic        click_sync;
	logic        click_prev; // for edge detect
	logic        click_rise;
	click_mode_e mode_meta;
	click_mode_e mode_sync;

	// action rules, hit and miss are final in both modes
	function automatic cell_state_e next_state(cell_state_e cur, click_mode_e m);
		cell_state_e nxt;
		nxt = cur;
		case (cur)
			CELL_EMPTY: nxt = (m == MODE_PLACE) ? CELL_SHIP : CELL_MISS;
			CELL_SHIP:  nxt = (m == MODE_PLACE) ? CELL_EMPTY : CELL_HIT;
			default:    nxt = cur;
		endcase
		return nxt;
	endfunction

	// switch and click come from the board, two flop sync
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			click_meta <= 1'b0;
			click_sync <= 1'b0;
			click_prev <= 1'b0;
			mode_meta  <= MODE_PLACE;
			mode_sync  <= MODE_PLACE;
		end else begin
			click_meta <= click;
			click_sync <= click_meta;
			click_prev <= click_sync;
			mode_meta  <= mode;
			mode_sync  <= mode_meta;
		end
	end

	assign click_rise = click_sync && !click_prev;

	// pointer pixel to cell, one clock behind the pointer
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			ptr_cell <= '0;
		end else begin
			ptr_cell.x <= 4'(ptr_x >> CELL_SHIFT);
			ptr_cell.y <= 4'(ptr_y >> CELL_SHIFT);
		end
	end

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			for (int y = 0; y < GRID_N; y++) begin
				for (int x = 0; x < GRID_N; x++) begin
					cells[y][x] <= CELL_EMPTY;
				end
			end
		end else if (click_rise) begin
			cells[ptr_cell.y][ptr_cell.x] <= next_state(cells[ptr_cell.y][ptr_cell.x], mode_sync);
		end
	end

	// renderer port, cells outside the grid read as empty
	always_ff @(posedge clk_in) begin
		if (int'(rd_cell.x) < GRID_N && int'(rd_cell.y) < GRID_N) begin
			rd_state <= cells[rd_cell.y][rd_cell.x];
		end else begin
			rd_state <= CELL_EMPTY;
		end
	end

	// no cell moves except right after a synchronised click edge
	a_write_on_click: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		($past(rst_n) && !$past(click_rise)) |-> $stable(cells)
	);

endmodule

`default_nettype wire

// File: hw/pixel_renderer.sv
`default_nettype none

module pixel_renderer import grid_pkg::*; #(
	parameter int GRID_N     = 10,
	parameter int CELL_SHIFT = 5
) (
	input  logic        clk_in,
	input  logic        rst_n,
	input  logic        pix_tick,
	input  pixel_pos_t  pos,
	input  logic        hsync,
	input  logic        vsync,
	input  cell_idx_t   ptr_cell,
	input  cell_state_e rd_state,
	output cell_idx_t   rd_cell,
	output vga_out_t    vga_out
);

	localparam int         GRID_PIX  = GRID_N << CELL_SHIFT;   // grid side in pixels
	localparam logic [9:0] CELL_MASK = 10'((1 << CELL_SHIFT) - 1);

	// stage 1 registers
	cell_idx_t cell1;
	logic      active1;
	logic      in_grid1;
	logic      border1;
	logic      hs1;
	logic      vs1;
	logic      tick_d; // stage 2 enable, one clock after the tick
	rgb_t      color;

	function automatic rgb_t state_color(cell_state_e s);
		rgb_t c;
		case (s)
			CELL_SHIP: c = COLOR_SHIP;
			CELL_HIT:  c = COLOR_HIT;
			CELL_MISS: c = COLOR_MISS;
			default:   c = COLOR_EMPTY;
		endcase
		return c;
	endfunction

	// read address straight from the raster so rd_state
	// is latched on the same edge as stage 1
	assign rd_cell = '{x: 4'(pos.x >> CELL_SHIFT), y: 4'(pos.y >> CELL_SHIFT)};

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			active1  <= 1'b0;
			in_grid1 <= 1'b0;
			border1  <= 1'b0;
			hs1      <= 1'b1;
			vs1      <= 1'b1;
		end else if (pix_tick) begin
			active1  <= pos.active;
			in_grid1 <= (pos.x < 10'(GRID_PIX)) && (pos.y < 10'(GRID_PIX));
			// top and left pixel of each cell
			border1  <= ((pos.x & CELL_MASK) == '0) || ((pos.y & CELL_MASK) == '0);
			hs1      <= hsync;
			vs1      <= vsync;
		end
	end

	always_ff @(posedge clk_in) begin
		if (pix_tick) begin
			cell1 <= rd_cell;
		end
	end

	// colour priority
	always_comb begin
		if (!active1 || !in_grid1) begin
			color = COLOR_BLACK;
		end else if (border1) begin
			color = COLOR_BORDER;
		end else if (cell1 == ptr_cell) begin
			color = COLOR_CURSOR_TINT; // tint replaces the state colour
		end else begin
			color = state_color(rd_state);
		end
	end

	// stage 2, colour and syncs leave in the same register
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			tick_d  <= 1'b0;
			vga_out <= '{rgb: COLOR_BLACK, hsync: 1'b1, vsync: 1'b1};
		end else begin
			tick_d <= pix_tick;
			if (tick_d) begin
				vga_out <= '{rgb: color, hsync: hs1, vsync: vs1};
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/vga_top.sv
`default_nettype none

module vga_top import grid_pkg::*; #(
	parameter int H_ACTIVE   = 640,
	parameter int H_FRONT    = 16,
	parameter int H_SYNC     = 96,
	parameter int H_BACK     = 48,
	parameter int V_ACTIVE   = 480,
	parameter int V_FRONT    = 10,
	parameter int V_SYNC     = 2,
	parameter int V_BACK     = 33,
	parameter int PIX_DIV    = 2,      // 50 MHz board clock to 25 MHz pixel rate
	parameter int MOVE_DIV   = 100000, // pointer speed
	parameter int GRID_N     = 10,
	parameter int CELL_SHIFT = 5       // 32 pixel cells
) (
	input  logic        clk_in,
	input  logic        rst_n,
	input  buttons_t    buttons,
	input  logic        click,
	input  click_mode_e mode,
	output logic [7:0]  led,
	output vga_out_t    vga_out
);

	logic        pix_tick;
	logic        move_tick;
	pixel_pos_t  pos;
	logic        hsync;
	logic        vsync;
	logic [9:0]  ptr_x;
	logic [9:0]  ptr_y;
	cell_idx_t   ptr_cell;
	cell_idx_t   rd_cell;
	cell_state_e rd_state;

	assign led = {ptr_cell.y, ptr_cell.x}; // pointer cell on the leds

	tick_gen #(.DIV(PIX_DIV)) u_pix_tick (
		.clk_in (clk_in),
		.rst_n  (rst_n),
		.tick   (pix_tick)
	);

	tick_gen #(.DIV(MOVE_DIV)) u_move_tick (
		.clk_in (clk_in),
		.rst_n  (rst_n),
		.tick   (move_tick)
	);

	vga_sync #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
	) u_sync (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.pix_tick (pix_tick),
		.pos      (pos),
		.hsync    (hsync),
		.vsync    (vsync)
	);

	pointer_mover #(.GRID_N(GRID_N), .CELL_SHIFT(CELL_SHIFT)) u_pointer (
		.clk_in    (clk_in),
		.rst_n     (rst_n),
		.move_tick (move_tick),
		.buttons   (buttons),
		.ptr_x     (ptr_x),
		.ptr_y     (ptr_y)
	);

	grid_engine #(.GRID_N(GRID_N), .CELL_SHIFT(CELL_SHIFT)) u_grid (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.ptr_x    (ptr_x),
		.ptr_y    (ptr_y),
		.click    (click),
		.mode     (mode),
		.rd_cell  (rd_cell),
		.ptr_cell (ptr_cell),
		.rd_state (rd_state)
	);

	pixel_renderer #(.GRID_N(GRID_N), .CELL_SHIFT(CELL_SHIFT)) u_render (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.pix_tick (pix_tick),
		.pos      (pos),
		.hsync    (hsync),
		.vsync    (vsync),
		.ptr_cell (ptr_cell),
		.rd_state (rd_state),
		.rd_cell  (rd_cell),
		.vga_out  (vga_out)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

// free running testbench clock
module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk; // half period per phase
	end

endmodule

`default_nettype wire

// File: tests/tb_vga_top.sv
`default_nettype none

module tb_vga_top import grid_pkg::*; ();

	// tiny screen so a frame is short
	localparam int H_ACTIVE = 32;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 2;
	localparam int V_ACTIVE = 24;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 3;
	localparam int V_BACK = 2;
	localparam int PIX_DIV = 2;
	localparam int MOVE_DIV = 4;
	localparam int GRID_N = 4;
	localparam int CELL_SHIFT = 2;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int CELL_PX = 1 << CELL_SHIFT;
	localparam int FRAME_CLK = H_TOTAL * V_TOTAL * PIX_DIV;
	// frames per test: sync 4, reset frame 3, pointer 1, place 6, fire 4, reset 3
	localparam int TEST_FRAMES = 4 + 3 + 1 + 6 + 4 + 3;
	localparam int TIMEOUT_CYC = TEST_FRAMES * FRAME_CLK * 3 / 2;

	logic        clk_in;
	logic        rst_n;
	buttons_t    buttons;
	logic        click;
	click_mode_e mode;
	logic [7:0]  led;
	vga_out_t    vga_out;
	cell_idx_t   led_cell;

	cell_state_e model [GRID_N][GRID_N]; // expected cell states, [y][x]
	cell_idx_t   exp_ptr;                // expected pointer cell
	int          seed = 87697;
	int          err_count = 0;
	int          cycles = 0;

	// raster tracker state, all describing the same vga_out sample
	logic trk_lock;
	int   trk_x;
	int   trk_y;
	int   trk_sub; // clock within the pixel
	rgb_t trk_rgb;
	logic hs_prev;
	logic vs_prev;

	assign led_cell = '{x: led[3:0], y: led[7:4]};

	tb_clock #(.PERIOD(8)) u_clock (.clk(clk_in));

	vga_top #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
		.PIX_DIV (PIX_DIV), .MOVE_DIV (MOVE_DIV), .GRID_N (GRID_N), .CELL_SHIFT (CELL_SHIFT)
	) dut (
		.clk_in  (clk_in),
		.rst_n   (rst_n),
		.buttons (buttons),
		.click   (click),
		.mode    (mode),
		.led     (led),
		.vga_out (vga_out)
	);

	// rebuild x and y from the sync edges seen on vga_out
	always @(posedge clk_in) begin
		if (!rst_n) begin
			trk_lock <= 1'b0;
			trk_x    <= 0;
			trk_y    <= 0;
			trk_sub  <= 0;
			trk_rgb  <= COLOR_BLACK;
			hs_prev  <= 1'b1;
			vs_prev  <= 1'b1;
		end else begin
			hs_prev <= vga_out.hsync;
			vs_prev <= vga_out.vsync;
			trk_rgb <= vga_out.rgb;
			if (vs_prev && !vga_out.vsync) begin // vsync falls at column 0
				trk_lock <= 1'b1;
				trk_x    <= 0;
				trk_y    <= V_ACTIVE + V_FRONT;
				trk_sub  <= 0;
			end else if (hs_prev && !vga_out.hsync) begin
				trk_x   <= H_ACTIVE + H_FRONT;
				trk_sub <= 0;
			end else if (trk_sub == PIX_DIV - 1) begin
				trk_sub <= 0;
				if (trk_x == H_TOTAL - 1) begin
					trk_x <= 0;
					trk_y <= (trk_y == V_TOTAL - 1) ? 0 : trk_y + 1;
				end else begin
					trk_x <= trk_x + 1;
				end
			end else begin
				trk_sub <= trk_sub + 1;
			end
		end
	end

	always @(posedge clk_in) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
			$display("Done: errors found");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic report_mismatch(input string msg);
		err_count++;
		$display("MISMATCH at time %0t: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_rgb(input rgb_t act, input rgb_t exp, input string what);
		if (act !== exp) begin
			report_mismatch($sformatf("%s: rgb %03h, expected %03h", what, act, exp));
		end
	endtask

	task automatic check_cell(input cell_idx_t act, input cell_idx_t exp, input string what);
		if (act !== exp) begin
			report_mismatch($sformatf("%s: cell (%0d,%0d), expected (%0d,%0d)",
				what, act.x, act.y, exp.x, exp.y));
		end
	endtask

	task automatic check_count(input int act, input int exp, input string what);
		if (act != exp) begin
			report_mismatch($sformatf("%s: %0d, expected %0d", what, act, exp));
		end
	endtask

	// colour a pixel should have, from the drawing rules
	function automatic rgb_t expect_color(input int x, input int y);
		cell_idx_t c;
		if (x >= H_ACTIVE || y >= V_ACTIVE) return COLOR_BLACK; // blanking
		if (x >= GRID_N * CELL_PX || y >= GRID_N * CELL_PX) return COLOR_BLACK;
		if (x % CELL_PX == 0 || y % CELL_PX == 0) return COLOR_BORDER;
		c.x = 4'(x / CELL_PX);
		c.y = 4'(y / CELL_PX);
		if (c == exp_ptr) return COLOR_CURSOR_TINT;
		case (model[c.y][c.x])
			CELL_SHIP: return COLOR_SHIP;
			CELL_HIT:  return COLOR_HIT;
			CELL_MISS: return COLOR_MISS;
			default:   return COLOR_EMPTY;
		endcase
	endfunction

	task automatic clear_model();
		for (int y = 0; y < GRID_N; y++) begin
			for (int x = 0; x < GRID_N; x++) begin
				model[y][x] = CELL_EMPTY;
			end
		end
		exp_ptr = '0;
	endtask

	task automatic random_cell(output cell_idx_t c);
		c.x = 4'($unsigned($random(seed)) % GRID_N);
		c.y = 4'($unsigned($random(seed)) % GRID_N);
	endtask

	// compare one whole frame, pixel by pixel
	task automatic check_frame(input string tag);
		while (!(trk_lock && trk_x == 0 && trk_y == 0 && trk_sub == 0)) @(negedge clk_in);
		for (int n = 0; n < H_TOTAL * V_TOTAL; n++) begin
			check_rgb(trk_rgb, expect_color(trk_x, trk_y),
				$sformatf("%s, pixel (%0d,%0d)", tag, trk_x, trk_y));
			repeat (PIX_DIV) @(negedge clk_in);
		end
	endtask

	// hold buttons until led reaches goal, every step checked, then test the clamp
	task automatic sweep(input buttons_t b, input cell_idx_t goal);
		cell_idx_t prev;
		cell_idx_t step;
		buttons = b;
		while (led_cell != goal) begin
			prev = led_cell;
			while (led_cell == prev) @(negedge clk_in);
			step = prev;
			if (b.east) step.x = prev.x + 4'd1;
			if (b.west) step.x = prev.x - 4'd1;
			if (b.south) step.y = prev.y + 4'd1;
			if (b.north) step.y = prev.y - 4'd1;
			check_cell(led_cell, step, "pointer step");
		end
		repeat (8 * MOVE_DIV) @(negedge clk_in); // keep pushing against the edge
		check_cell(led_cell, goal, "pointer held at grid edge");
		buttons = '0;
		repeat (4) @(negedge clk_in);
		exp_ptr = goal;
	endtask

	task automatic move_to(input cell_idx_t target);
		buttons_t b;
		while (led_cell != target) begin
			b = '0;
			b.east  = led_cell.x < target.x;
			b.west  = led_cell.x > target.x;
			b.south = led_cell.y < target.y;
			b.north = led_cell.y > target.y;
			buttons = b;
			@(negedge clk_in);
		end
		buttons = '0;
		repeat (4) @(negedge clk_in); // let the release pass the synchroniser
		exp_ptr = target;
		check_cell(led_cell, target, "pointer after move");
	endtask

	// one click at the pointer cell, model follows the game rules
	task automatic click_at(input click_mode_e m);
		cell_state_e cur;
		mode = m;
		repeat (4) @(negedge clk_in); // mode through its sync flops first
		click = 1'b1;
		repeat (4) @(negedge clk_in);
		click = 1'b0;
		repeat (4) @(negedge clk_in);
		cur = model[exp_ptr.y][exp_ptr.x];
		if (m == MODE_PLACE) begin
			if (cur == CELL_EMPTY) model[exp_ptr.y][exp_ptr.x] = CELL_SHIP;
			else if (cur == CELL_SHIP) model[exp_ptr.y][exp_ptr.x] = CELL_EMPTY;
		end else begin
			if (cur == CELL_SHIP) model[exp_ptr.y][exp_ptr.x] = CELL_HIT;
			else if (cur == CELL_EMPTY) model[exp_ptr.y][exp_ptr.x] = CELL_MISS;
		end
	endtask

	task automatic sync_timing_test();
		int clks;
		while (vga_out.hsync !== 1'b1) @(negedge clk_in);
		while (vga_out.hsync !== 1'b0) @(negedge clk_in);
		clks = 0;
		while (vga_out.hsync === 1'b0) begin
			check_rgb(vga_out.rgb, COLOR_BLACK, "rgb during hsync");
			clks++;
			@(negedge clk_in);
		end
		check_count(clks, H_SYNC * PIX_DIV, "hsync low clocks");
		clks = 0; // one full line, high then low
		while (vga_out.hsync === 1'b1) begin
			clks++;
			@(negedge clk_in);
		end
		while (vga_out.hsync === 1'b0) begin
			clks++;
			@(negedge clk_in);
		end
		check_count(clks, H_TOTAL * PIX_DIV, "line period clocks");
		while (vga_out.vsync !== 1'b0) @(negedge clk_in);
		clks = 0;
		while (vga_out.vsync === 1'b0) begin
			check_rgb(vga_out.rgb, COLOR_BLACK, "rgb during vsync");
			clks++;
			@(negedge clk_in);
		end
		check_count(clks, V_SYNC * H_TOTAL * PIX_DIV, "vsync low clocks");
		check_frame("sync frame"); // blanking black everywhere
	endtask

	task automatic reset_frame_test();
		check_cell(led_cell, '0, "led after reset");
		check_frame("reset frame");
	endtask

	task automatic pointer_test();
		sweep('{east: 1'b1, default: 1'b0}, '{x: 4'(GRID_N - 1), y: 4'd0});
		sweep('{west: 1'b1, default: 1'b0}, '{x: 4'd0, y: 4'd0});
		sweep('{south: 1'b1, default: 1'b0}, '{x: 4'd0, y: 4'(GRID_N - 1)});
		sweep('{north: 1'b1, default: 1'b0}, '{x: 4'd0, y: 4'd0});
	endtask

	task automatic place_test();
		cell_idx_t tgt;
		cell_idx_t away;
		random_cell(tgt);
		away = tgt;
		away.x = 4'((tgt.x + 1) % GRID_N); // neighbour, so the tint leaves tgt
		move_to(tgt);
		click_at(MODE_PLACE);
		move_to(away);
		check_frame("ship placed");
		move_to(tgt);
		click_at(MODE_PLACE);
		move_to(away);
		check_frame("ship removed");
	endtask

	task automatic fire_test();
		cell_idx_t ship_c;
		cell_idx_t other;
		cell_idx_t away;
		random_cell(ship_c);
		other = ship_c;
		other.y = 4'((ship_c.y + 1 + $unsigned($random(seed)) % (GRID_N - 1)) % GRID_N);
		away = ship_c;
		away.x = 4'((ship_c.x + 1) % GRID_N);
		move_to(ship_c);
		click_at(MODE_PLACE);
		click_at(MODE_FIRE);  // ship to hit
		move_to(other);
		click_at(MODE_FIRE);  // empty to miss
		click_at(MODE_FIRE);  // miss stays
		move_to(ship_c);
		click_at(MODE_FIRE);  // hit stays
		click_at(MODE_PLACE); // place cannot undo a hit
		move_to(away);
		check_frame("after firing");
	endtask

	task automatic reset_test();
		cell_idx_t c;
		random_cell(c);
		c.x = 4'(1 + c.x % (GRID_N - 1)); // never (0,0), so the return is visible
		move_to(c);
		rst_n = 1'b0;
		repeat (5) @(negedge clk_in);
		rst_n = 1'b1;
		clear_model();
		@(negedge clk_in);
		check_cell(led_cell, '0, "pointer after mid-run reset");
		check_frame("after mid-run reset");
	endtask

	initial begin
		rst_n   = 1'b0;
		buttons = '0;
		click   = 1'b0;
		mode    = MODE_PLACE;
		clear_model();
		repeat (5) @(posedge clk_in);
		@(negedge clk_in);
		rst_n = 1'b1;
		sync_timing_test();
		reset_frame_test();
		pointer_test();
		place_test();
		fire_test();
		reset_test();
		if (err_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hw/grid_pkg.sv
hw/tick_gen.sv
hw/vga_sync.sv
hw/pointer_mover.sv
hw/grid_engine.sv
hw/pixel_renderer.sv
hw/vga_top.sv
tests/tb_clock.sv
tests/tb_vga_top.sv

// File: Bender.yml
package:
  name: vga_grid_game

sources:
  # design, package first
  - files:
      - hw/grid_pkg.sv
      - hw/tick_gen.sv
      - hw/vga_sync.sv
      - hw/pointer_mover.sv
      - hw/grid_engine.sv
      - hw/pixel_renderer.sv
      - hw/vga_top.sv
  # simulation only
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_vga_top.sv
